// ==== rtl/pongPkg.sv ====
package pongPkg;

	typedef logic [7:0] coordX_t; // pixel column, 0 is the left edge
	typedef logic [6:0] coordY_t; // pixel row, 0 is the top edge
	typedef logic [2:0] colour_t; // one bit each for red, green, blue

	localparam colour_t colourBlack = 3'b000;
	localparam colour_t colourWhite = 3'b111;

	// one pixel on its way to the framebuffer
	typedef struct packed
	{
		coordX_t x;
		coordY_t y;
		colour_t colour;
	} pixelWrite_t;

	// wishbone classic master outputs, adr is {row, column}
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [14:0] adr;
		colour_t dat;
	} wbMasterOut_t;

	typedef enum logic [2:0]
	{
		opClearScreen, // whole screen black
		opDrawPaddle,  // full 2x16 paddle white
		opPaddleUp,    // erase bottom row, draw new top row
		opPaddleDown,  // erase top row, draw new bottom row
		opEraseBall,
		opDrawBall
	} spriteOp_t;

	typedef enum logic [3:0]
	{
		stClear,
		stDrawPaddle,
		stDrawBall,
		stWaitStart,
		stStepWait,
		stMovePaddle,
		stEraseBall,
		stMoveBall,
		stDrawNewBall,
		stGameOver
	} gameState_t;

	localparam int PaddleHeight = 16;
	localparam int PaddleWidth = 2; // paddle sits in columns 0 and 1
	localparam int BallSize = 2;
	localparam int InitialPaddleY = 55;
	localparam int InitialBallX = 79;
	localparam int InitialBallY = 59;
	localparam logic InitialMoveRight = 1'b0; // ball starts going left
	localparam logic InitialMoveDown = 1'b0;  // and up

endpackage

// ==== rtl/gameController.sv ====
`timescale 1ns/1ns

module gameController
#(
	parameter int ScreenWidth = 160,
	parameter int ScreenHeight = 120,
	parameter int StepPeriod = 50
)
(
	input  logic clock,
	input  logic resetBallCounterCommand,
	input  logic startGame,
	input  logic paddleUp,
	input  logic paddleDown,
	input  logic opDone,
	input  logic missed,
	input  logic canMoveUp,
	input  logic canMoveDown,
	output logic opStart,
	output pongPkg::spriteOp_t op,
	output logic stepBall,
	output logic movePaddle,
	output logic moveUp,
	output logic restartBall,
	output logic gameOver
);
	import pongPkg::*;

	localparam int TimerWidth = $clog2(StepPeriod + 1);

	gameState_t state;
	gameState_t nextState;
	logic opPending; // sprite op launched and not yet done
	logic opState;   // current state owns a sprite op
	logic [TimerWidth-1:0] stepCount;
	logic stepExpired;
	logic moveAllowed;

	// the start layout has to fit inside the screen
	if (InitialPaddleY + PaddleHeight > ScreenHeight || InitialBallY + BallSize > ScreenHeight
		|| InitialBallX + BallSize > ScreenWidth || StepPeriod < 1)
	begin : layoutCheck
		$fatal(1, "initial paddle or ball lies outside the screen");
	end

	assign stepExpired = (state == stStepWait) && (stepCount == TimerWidth'(StepPeriod - 1));
	assign moveAllowed = paddleUp ? canMoveUp : (paddleDown && canMoveDown); // up wins

	always_comb
	begin
		nextState = state;
		case (state)
			stClear:      if (opDone) nextState = stDrawPaddle;
			stDrawPaddle: if (opDone) nextState = stDrawBall;
			stDrawBall:   if (opDone) nextState = stWaitStart;
			stWaitStart:  if (startGame) nextState = stStepWait;
			stStepWait:   if (stepExpired) nextState = moveAllowed ? stMovePaddle : stEraseBall;
			stMovePaddle: if (opDone) nextState = stEraseBall;
			stEraseBall:  if (opDone) nextState = stMoveBall;
			stMoveBall:   nextState = stDrawNewBall; // physics updates in one edge
			stDrawNewBall:
			begin
				if (opDone)
					nextState = (missed && !gameOver) ? stGameOver : stStepWait;
			end
			stGameOver:   if (startGame) nextState = stEraseBall; // restart via erase
			default:      nextState = stClear;
		endcase
	end

	// sprite op for each drawing phase
	always_comb
	begin
		opState = 1'b1;
		op = opDrawBall;
		case (state)
			stClear:       op = opClearScreen;
			stDrawPaddle:  op = opDrawPaddle;
			stMovePaddle:  op = moveUp ? opPaddleUp : opPaddleDown;
			stEraseBall:   op = opEraseBall;
			stDrawBall,
			stDrawNewBall: op = opDrawBall;
			default:       opState = 1'b0;
		endcase
	end

	assign stepBall = (state == stMoveBall) && !gameOver;
	assign restartBall = (state == stMoveBall) && gameOver; // game over step resets the ball
	assign movePaddle = (state == stMovePaddle) && opDone;  // row moves after its redraw

	always_ff @(posedge clock)
	begin
		if (resetBallCounterCommand)
		begin
			state <= stClear;
			opStart <= 1'b0;
			opPending <= 1'b0;
			stepCount <= '0;
			moveUp <= 1'b0;
			gameOver <= 1'b0;
		end
		else
		begin
			state <= nextState;
			opStart <= opState && !opPending; // one launch per state visit
			if (opPending)
				opPending <= !opDone;
			else
				opPending <= opState;
			stepCount <= (state == stStepWait) ? stepCount + 1'b1 : '0;
			if (stepExpired)
				moveUp <= paddleUp; // direction held through the paddle op
			if (state == stDrawNewBall && opDone)
				gameOver <= !gameOver && missed; // restart redraw drops it
		end
	end

	// rasterizer only ever holds one op
	opOneAtATime: assert property (@(posedge clock) disable iff (resetBallCounterCommand)
		opStart |=> (!opStart until_with opDone));

endmodule

// ==== rtl/ballPhysics.sv ====
`timescale 1ns/1ns

module ballPhysics
#(
	parameter int ScreenWidth = 160,
	parameter int ScreenHeight = 120
)
(
	input  logic clock,
	input  logic resetBallCounterCommand,
	input  logic stepBall,
	input  logic restartBall,
	input  pongPkg::coordY_t paddleY,
	output pongPkg::coordX_t ballX,
	output pongPkg::coordY_t ballY,
	output logic [3:0] score,
	output logic missed
);
	import pongPkg::*;

	localparam coordX_t RightWallX = coordX_t'(ScreenWidth - BallSize);   // last left column
	localparam coordY_t BottomWallY = coordY_t'(ScreenHeight - BallSize); // last top row

	logic moveRight;
	logic moveDown;
	coordX_t nextX;
	coordY_t nextY;
	logic paddleHit;

	assign nextX = moveRight ? ballX + 1'b1 : ballX - 1'b1;
	assign nextY = moveDown ? ballY + 1'b1 : ballY - 1'b1;

	// new ball rows overlap the paddle rows, one bit wider so nothing wraps
	assign paddleHit = ({1'b0, nextY} + 8'(BallSize - 1) >= {1'b0, paddleY})
		&& ({1'b0, nextY} <= {1'b0, paddleY} + 8'(PaddleHeight - 1));

	always_ff @(posedge clock)
	begin
		if (resetBallCounterCommand || restartBall)
		begin
			ballX <= coordX_t'(InitialBallX);
			ballY <= coordY_t'(InitialBallY);
			moveRight <= InitialMoveRight;
			moveDown <= InitialMoveDown;
			score <= '0;
			missed <= 1'b0;
		end
		else if (stepBall)
		begin
			ballX <= nextX;
			ballY <= nextY;
			// top and bottom walls
			if (nextY == '0)
				moveDown <= 1'b1;
			else if (nextY == BottomWallY)
				moveDown <= 1'b0;
			// right wall, else a paddle return
			if (nextX == RightWallX)
				moveRight <= 1'b0;
			else if (nextX == coordX_t'(PaddleWidth) && !moveRight && paddleHit)
			begin
				moveRight <= 1'b1;
				score <= score + 4'd1; // wraps at 16
			end
			if (nextX == '0)
				missed <= 1'b1; // held until restart
		end
	end

	// a step never carries the ball off screen
	ballOnScreen: assert property (@(posedge clock) disable iff (resetBallCounterCommand)
		stepBall |=> (ballX <= RightWallX) && (ballY <= BottomWallY));

endmodule

// ==== rtl/paddleTracker.sv ====
`timescale 1ns/1ns

module paddleTracker
#(
	parameter int ScreenHeight = 120
)
(
	input  logic clock,
	input  logic resetBallCounterCommand,
	input  logic movePaddle,
	input  logic moveUp,
	output pongPkg::coordY_t paddleY,
	output logic canMoveUp,
	output logic canMoveDown
);
	import pongPkg::*;

	localparam coordY_t LowestPaddleY = coordY_t'(ScreenHeight - PaddleHeight);

	assign canMoveUp = (paddleY != '0);
	assign canMoveDown = (paddleY < LowestPaddleY); // bottom row stays on screen

	always_ff @(posedge clock)
	begin
		if (resetBallCounterCommand)
			paddleY <= coordY_t'(InitialPaddleY);
		else if (movePaddle && moveUp && canMoveUp)
			paddleY <= paddleY - 1'b1;
		else if (movePaddle && !moveUp && canMoveDown)
			paddleY <= paddleY + 1'b1;
	end

	// controller only asks for moves it was told are free
	paddleInRange: assert property (@(posedge clock) disable iff (resetBallCounterCommand)
		movePaddle |-> (moveUp ? canMoveUp : canMoveDown) ##1 (paddleY <= LowestPaddleY));

endmodule

// ==== rtl/spriteRasterizer.sv ====
`timescale 1ns/1ns

module spriteRasterizer
#(
	parameter int ScreenWidth = 160,
	parameter int ScreenHeight = 120
)
(
	input  logic clock,
	input  logic resetBallCounterCommand,
	input  logic opStart,
	input  pongPkg::spriteOp_t op,
	input  pongPkg::coordX_t ballX,
	input  pongPkg::coordY_t ballY,
	input  pongPkg::coordY_t paddleY,
	input  logic pixelAccepted,
	output pongPkg::pixelWrite_t pixel,
	output logic pixelValid,
	output logic opDone
);
	import pongPkg::*;

	spriteOp_t curOp; // op being walked
	coordX_t baseX;   // top left corner, latched at start
	coordY_t baseY;
	coordX_t scanX;   // x runs fastest
	coordY_t scanY;
	coordX_t lastX;
	coordY_t lastY;
	logic lastPixel;

	// extent of each shape
	always_comb
	begin
		lastX = coordX_t'(BallSize - 1);
		lastY = coordY_t'(BallSize - 1);
		case (curOp)
			opClearScreen:
			begin
				lastX = coordX_t'(ScreenWidth - 1);
				lastY = coordY_t'(ScreenHeight - 1);
			end
			opDrawPaddle:
			begin
				lastX = coordX_t'(PaddleWidth - 1);
				lastY = coordY_t'(PaddleHeight - 1);
			end
			opPaddleUp, opPaddleDown:
			begin
				lastX = coordX_t'(PaddleWidth - 1);
				lastY = coordY_t'(1); // one erase row then one draw row
			end
			default: ;
		endcase
	end

	assign lastPixel = (scanX == lastX) && (scanY == lastY);

	always_comb
	begin
		pixel.x = baseX + scanX;
		pixel.y = baseY + scanY;
		pixel.colour = colourWhite;
		case (curOp)
			opClearScreen, opEraseBall: pixel.colour = colourBlack;
			opPaddleUp:
			begin
				pixel.y = (scanY == '0) ? baseY + coordY_t'(PaddleHeight - 1) : baseY - 1'b1;
				pixel.colour = (scanY == '0) ? colourBlack : colourWhite;
			end
			opPaddleDown:
			begin
				pixel.y = (scanY == '0) ? baseY : baseY + coordY_t'(PaddleHeight);
				pixel.colour = (scanY == '0) ? colourBlack : colourWhite;
			end
			default: ;
		endcase
	end

	// op and origin, loaded once per op
	always_ff @(posedge clock)
	begin
		if (opStart)
		begin
			curOp <= op;
			baseX <= (op == opEraseBall || op == opDrawBall) ? ballX : '0; // paddle is at x 0
			case (op)
				opClearScreen: baseY <= '0;
				opEraseBall, opDrawBall: baseY <= ballY;
				default: baseY <= paddleY;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (resetBallCounterCommand)
		begin
			pixelValid <= 1'b0;
			opDone <= 1'b0;
			scanX <= '0;
			scanY <= '0;
		end
		else
		begin
			opDone <= 1'b0;
			if (opStart)
			begin
				scanX <= '0;
				scanY <= '0;
				pixelValid <= 1'b1;
			end
			else if (pixelValid && pixelAccepted) // step only once the bus took it
			begin
				if (scanX == lastX)
				begin
					scanX <= '0;
					scanY <= scanY + 1'b1;
				end
				else
					scanX <= scanX + 1'b1;
				if (lastPixel)
				begin
					pixelValid <= 1'b0;
					opDone <= 1'b1; // one cycle after the last acknowledge
				end
			end
		end
	end

endmodule

// ==== rtl/pixelBusMaster.sv ====
`timescale 1ns/1ns

module pixelBusMaster
(
	input  logic clock,
	input  logic resetBallCounterCommand,
	input  pongPkg::pixelWrite_t pixel,
	input  logic pixelValid,
	input  logic wbAck,
	output pongPkg::wbMasterOut_t wbOut,
	output logic pixelAccepted
);
	import pongPkg::*;

	logic busCyc;
	logic busStb;
	logic [14:0] busAdr; // row in the upper bits
	colour_t busDat;

	assign wbOut = '{cyc: busCyc, stb: busStb, we: busCyc, adr: busAdr, dat: busDat};
	assign pixelAccepted = busStb && wbAck; // write ends on this edge

	always_ff @(posedge clock)
	begin
		if (resetBallCounterCommand)
		begin
			busCyc <= 1'b0;
			busStb <= 1'b0;
		end
		else if (busStb)
		begin
			if (wbAck)
			begin
				busCyc <= 1'b0; // idle cycle before the next pixel
				busStb <= 1'b0;
			end
		end
		else if (pixelValid)
		begin
			busCyc <= 1'b1;
			busStb <= 1'b1;
		end
	end

	// request captured only while idle, then held through wait states
	always_ff @(posedge clock)
	begin
		if (!busStb && pixelValid)
		begin
			busAdr <= {pixel.y, pixel.x};
			busDat <= pixel.colour;
		end
	end

	stbNeedsCyc: assert property (@(posedge clock) disable iff (resetBallCounterCommand)
		wbOut.stb |-> wbOut.cyc);

	holdUntilAck: assert property (@(posedge clock) disable iff (resetBallCounterCommand)
		wbOut.stb && !wbAck |=> wbOut.stb && $stable(wbOut.adr) && $stable(wbOut.dat));

endmodule

// ==== rtl/pongTop.sv ====
`timescale 1ns/1ns

module pongTop
#(
	parameter int ScreenWidth = 160,
	parameter int ScreenHeight = 120,
	parameter int StepPeriod = 50 // clock cycles per game step
)
(
	input  logic clock,
	input  logic resetBallCounterCommand,
	input  logic startGame,
	input  logic paddleUp,
	input  logic paddleDown,
	output pongPkg::wbMasterOut_t wbOut,
	input  logic wbAck,
	output logic [3:0] score,
	output logic gameOver
);
	import pongPkg::*;

	// controller to datapath
	logic opStart;
	spriteOp_t op;
	logic opDone;
	logic stepBall;
	logic restartBall;
	logic missed;
	logic movePaddle;
	logic moveUp;
	logic canMoveUp;
	logic canMoveDown;

	// positions shared by physics, tracker and rasterizer
	coordX_t ballX;
	coordY_t ballY;
	coordY_t paddleY;

	// rasterizer to bus master
	pixelWrite_t pixel;
	logic pixelValid;
	logic pixelAccepted;

	gameController #(.ScreenWidth(ScreenWidth), .ScreenHeight(ScreenHeight),
		.StepPeriod(StepPeriod)) controller (.*);

	ballPhysics #(.ScreenWidth(ScreenWidth), .ScreenHeight(ScreenHeight)) physics (.*);

	paddleTracker #(.ScreenHeight(ScreenHeight)) paddle (.*); // only rows matter here

	spriteRasterizer #(.ScreenWidth(ScreenWidth), .ScreenHeight(ScreenHeight)) rasterizer (.*);

	pixelBusMaster busMaster (.*);

endmodule

// ==== sim/pongTb.sv ====
`timescale 1ns/1ns

module pongTb;
	import pongPkg::*;

	localparam int ScreenWidth = 160;
	localparam int ScreenHeight = 120;
	localparam int StepPeriod = 50;
	localparam int WriteTimeout = 4 * StepPeriod + 50; // longest gap between two writes plus margin

	logic clock;
	logic resetBallCounterCommand;
	logic startGame;
	logic paddleUp;
	logic paddleDown;
	logic wbAck;
	wbMasterOut_t wbOut;
	logic [3:0] score;
	logic gameOver;

	integer seed;                  // wait state generator
	colour_t frameBuffer [0:32767]; // indexed by {row, column}
	logic [17:0] writeLog [$];     // {adr, dat} of every finished write in bus order
	logic inWrite;
	logic [14:0] heldAdr;
	colour_t heldDat;
	int waitLeft;

	// reference game state
	int refBallX;
	int refBallY;
	logic refRight;
	logic refDown;
	int refPaddleY;
	int refScore;
	logic refMissed;

	pongTop #(.ScreenWidth(ScreenWidth), .ScreenHeight(ScreenHeight), .StepPeriod(StepPeriod))
		u_dut (.*);

	always #10 clock = ~clock; // 20 ns period

	task automatic stopOnError();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic reportFailure(input string text);
		$display("ERROR at %0t: %s", $time, text);
		stopOnError();
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		stopOnError();
	endtask

	// framebuffer slave with 0 to 3 wait states per write
	always @(negedge clock)
	begin
		if (resetBallCounterCommand)
		begin
			wbAck = 1'b0;
			inWrite = 1'b0;
		end
		else if (wbAck)
		begin
			wbAck = 1'b0; // single cycle acknowledge
			assert (!wbOut.cyc && !wbOut.stb)
				else reportFailure("cyc or stb still high in the cycle after acknowledge");
		end
		else if (wbOut.stb)
		begin
			assert (wbOut.cyc && wbOut.we) else reportFailure("stb high without cyc and we");
			if (!inWrite)
			begin
				inWrite = 1'b1;
				heldAdr = wbOut.adr; // request must stay put from here on
				heldDat = wbOut.dat;
				waitLeft = $unsigned($random(seed)) % 4;
			end
			assert (wbOut.adr == heldAdr) else reportMismatch("wbOut.adr", heldAdr, wbOut.adr);
			assert (wbOut.dat == heldDat) else reportMismatch("wbOut.dat", heldDat, wbOut.dat);
			if (waitLeft == 0)
			begin
				wbAck = 1'b1;
				inWrite = 1'b0;
				frameBuffer[wbOut.adr] = wbOut.dat;
				writeLog.push_back({wbOut.adr, wbOut.dat});
			end
			else
				waitLeft--;
		end
	end

	// next logged write has to be this pixel
	task automatic expectWrite(input int x, input int y, input colour_t colour);
		logic [17:0] entry;
		logic [14:0] expAdr;
		int waited;
		waited = 0;
		expAdr = y * 256 + x;
		while (writeLog.size() == 0)
		begin
			@(negedge clock);
			waited++;
			assert (waited <= WriteTimeout) else reportFailure("timed out waiting for a pixel write");
		end
		entry = writeLog.pop_front();
		assert (entry[17:3] == expAdr) else reportMismatch("wbOut.adr", expAdr, entry[17:3]);
		assert (entry[2:0] == colour) else reportMismatch("wbOut.dat", colour, entry[2:0]);
	endtask

	task automatic expectBall(input int x, input int y, input colour_t colour);
		expectWrite(x, y, colour);
		expectWrite(x + 1, y, colour);
		expectWrite(x, y + 1, colour);
		expectWrite(x + 1, y + 1, colour);
	endtask

	task automatic expectQuiet(input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			assert (writeLog.size() == 0 && !wbOut.stb)
				else reportFailure("pixel write while the game should be idle");
		end
	endtask

	task automatic waitForGameOver(input logic level);
		int waited;
		waited = 0;
		while (gameOver !== level)
		begin
			@(negedge clock);
			waited++;
			assert (waited <= 20) else reportMismatch("gameOver", level, gameOver);
		end
	endtask

	task automatic pulseStart();
		@(negedge clock);
		startGame = 1'b1;
		@(negedge clock);
		startGame = 1'b0;
	endtask

	// one game step of buttons, paddle redraw, ball erase, move and redraw
	task automatic runStep(input logic up, input logic down);
		int nx;
		int ny;
		@(negedge clock);
		paddleUp = up; // sampled when the step timer runs out
		paddleDown = down;
		if (up)
		begin
			if (refPaddleY > 0)
			begin
				expectWrite(0, refPaddleY + 15, colourBlack);
				expectWrite(1, refPaddleY + 15, colourBlack);
				expectWrite(0, refPaddleY - 1, colourWhite);
				expectWrite(1, refPaddleY - 1, colourWhite);
				refPaddleY--;
			end
		end
		else if (down && refPaddleY < ScreenHeight - 16)
		begin
			expectWrite(0, refPaddleY, colourBlack);
			expectWrite(1, refPaddleY, colourBlack);
			expectWrite(0, refPaddleY + 16, colourWhite);
			expectWrite(1, refPaddleY + 16, colourWhite);
			refPaddleY++;
		end
		expectBall(refBallX, refBallY, colourBlack);
		nx = refRight ? refBallX + 1 : refBallX - 1;
		ny = refDown ? refBallY + 1 : refBallY - 1;
		if (ny == 0)
			refDown = 1'b1;
		else if (ny == ScreenHeight - 2)
			refDown = 1'b0;
		if (nx == ScreenWidth - 2)
			refRight = 1'b0;
		else if (nx == 2 && !refRight && ny + 1 >= refPaddleY && ny <= refPaddleY + 15)
		begin
			refRight = 1'b1; // returned by the paddle
			refScore = (refScore + 1) % 16;
		end
		if (nx == 0)
			refMissed = 1'b1;
		refBallX = nx;
		refBallY = ny;
		expectBall(refBallX, refBallY, colourWhite);
		assert (score == refScore) else reportMismatch("score", refScore, score);
		if (refMissed)
			waitForGameOver(1'b1);
		else
			assert (!gameOver) else reportMismatch("gameOver", 0, gameOver);
	endtask

	task automatic clearAfterReset();
		for (int y = 0; y < ScreenHeight; y++)
			for (int x = 0; x < ScreenWidth; x++)
				expectWrite(x, y, colourBlack); // row order with x fastest
		for (int y = 0; y < 16; y++)
		begin
			expectWrite(0, refPaddleY + y, colourWhite);
			expectWrite(1, refPaddleY + y, colourWhite);
		end
		expectBall(refBallX, refBallY, colourWhite);
		assert (score == 0) else reportMismatch("score", 0, score);
		assert (!gameOver) else reportMismatch("gameOver", 0, gameOver);
	endtask

	task automatic diagonalFlight();
		expectQuiet(5 * StepPeriod); // nothing moves before start
		pulseStart();
		repeat (10)
			runStep(1'b0, 1'b0);
	endtask

	task automatic paddleLimits();
		repeat (58)
			runStep(1'b1, 1'b0); // reaches row 0 and the last steps stay at the limit
		repeat (4)
			runStep(1'b0, 1'b1);
	endtask

	task automatic returnMissRestart();
		int steps;
		steps = 0;
		while (refScore == 0)
		begin
			runStep(1'b0, 1'b1);
			steps++;
			assert (steps < 40) else reportFailure("ball never returned by the paddle");
		end
		steps = 0;
		while (!refMissed) // paddle parks at the bottom far from the ball
		begin
			runStep(1'b0, 1'b1);
			steps++;
			assert (steps < 500) else reportFailure("ball never reached column 0");
		end
		expectQuiet(3 * StepPeriod);
		pulseStart();
		expectBall(refBallX, refBallY, colourBlack);
		refBallX = InitialBallX;
		refBallY = InitialBallY;
		refRight = 1'b0;
		refDown = 1'b0;
		refScore = 0;
		refMissed = 1'b0;
		expectBall(refBallX, refBallY, colourWhite);
		waitForGameOver(1'b0);
		assert (score == 0) else reportMismatch("score", 0, score);
		runStep(1'b0, 1'b1);
		runStep(1'b0, 1'b1);
	endtask

	// stored image against paddle and ball of the model
	task automatic imageCompare();
		colour_t expected;
		logic onPaddle;
		logic onBall;
		for (int y = 0; y < ScreenHeight; y++)
			for (int x = 0; x < ScreenWidth; x++)
			begin
				onPaddle = x < 2 && y >= refPaddleY && y < refPaddleY + 16;
				onBall = x >= refBallX && x < refBallX + 2 && y >= refBallY && y < refBallY + 2;
				expected = (onPaddle || onBall) ? colourWhite : colourBlack;
				assert (frameBuffer[y * 256 + x] == expected)
					else reportMismatch($sformatf("framebuffer x %0d y %0d", x, y), expected,
						frameBuffer[y * 256 + x]);
			end
	endtask

	initial
	begin
		clock = 1'b0;
		resetBallCounterCommand = 1'b1;
		startGame = 1'b0;
		paddleUp = 1'b0;
		paddleDown = 1'b0;
		wbAck = 1'b0;
		seed = 32'h6ec4428e;
		for (int a = 0; a < 32768; a++)
			frameBuffer[a] = colour_t'(a ^ (a >> 3) ^ (a >> 6) ^ (a >> 9) ^ (a >> 12));
		refBallX = InitialBallX;
		refBallY = InitialBallY;
		refRight = 1'b0; // left and up at start
		refDown = 1'b0;
		refPaddleY = InitialPaddleY;
		refScore = 0;
		refMissed = 1'b0;
		repeat (16)
			@(negedge clock);
		assert (!wbOut.cyc && !wbOut.stb) else reportFailure("bus active during reset");
		resetBallCounterCommand = 1'b0;
		clearAfterReset();
		diagonalFlight();
		paddleLimits();
		returnMissRestart();
		imageCompare();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== src.f ====
rtl/pongPkg.sv
rtl/gameController.sv
rtl/ballPhysics.sv
rtl/paddleTracker.sv
rtl/spriteRasterizer.sv
rtl/pixelBusMaster.sv
rtl/pongTop.sv
sim/pongTb.sv
